// File: source/bus_pkg.sv
package bus_pkg;

    // widths carried on the data bus
    typedef logic [63:0] addr_t;
    typedef logic [63:0] data_t;

    typedef enum logic [1:0] {
        size_byte   = 2'd0,
        size_half   = 2'd1,
        size_word   = 2'd2,
        size_double = 2'd3
    } bus_size_e;

    // wdata is already placed in its byte lanes
    typedef struct packed {
        addr_t     addr;
        bus_size_e size;
        logic      write;
        data_t     wdata;
    } bus_req_t;

    typedef struct packed {
        logic  ready;
        data_t rdata;
    } bus_rsp_t;

    // core-local timer region
    localparam addr_t clint_base = 64'h0000_0000_0200_0000;
    localparam addr_t clint_span = 64'h0000_0000_0001_0000;

    // register offsets inside the CLINT region
    localparam addr_t mtimecmp_offset = 64'h0000_0000_0000_4000;
    localparam addr_t mtime_offset    = 64'h0000_0000_0000_bff8;

endpackage

// File: source/lsu_pkg.sv
package lsu_pkg;

    typedef enum logic [3:0] {
        op_lb  = 4'd0,
        op_lh  = 4'd1,
        op_lw  = 4'd2,
        op_ld  = 4'd3,
        op_lbu = 4'd4,
        op_lhu = 4'd5,
        op_lwu = 4'd6,
        op_sb  = 4'd8,
        op_sh  = 4'd9,
        op_sw  = 4'd10,
        op_sd  = 4'd11
    } ls_op_e;

    // wdata is the raw register value, not yet lane-placed
    typedef struct packed {
        ls_op_e          op;
        bus_pkg::addr_t  addr;
        bus_pkg::data_t  wdata;
    } acc_req_t;

    // byte offset inside a doubleword
    typedef logic [2:0] lane_t;

    // how a narrow load fills the upper bits
    typedef enum logic {
        ext_zero = 1'b0,
        ext_sign = 1'b1
    } ext_e;

endpackage

// File: source/clint_timer.sv
`timescale 1ns/1ps

module clint_timer (
    input  logic            inst_selfdefine,
    input  logic            reset,
    input  logic            mtime_wr,
    input  bus_pkg::data_t  mtime_wdata,
    input  bus_pkg::data_t  mtimecmp,
    output bus_pkg::data_t  mtime,
    output logic            mtip
);

    // free running, a bus write takes priority over the tick
    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            mtime <= '0;
        end else if (mtime_wr) begin
            mtime <= mtime_wdata;
        end else begin
            mtime <= mtime + 64'd1;
        end
    end

    // unsigned compare, one cycle late
    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            mtip <= 1'b0;
        end else begin
            mtip <= (mtime >= mtimecmp);
        end
    end

endmodule

// File: source/clint_regs.sv
`timescale 1ns/1ps

module clint_regs (
    input  logic               inst_selfdefine,
    input  logic               reset,
    input  logic               clint_valid,
    input  bus_pkg::bus_req_t  clint_req,
    output bus_pkg::bus_rsp_t  clint_rsp,
    input  bus_pkg::data_t     mtime,
    output logic               mtime_wr,
    output bus_pkg::data_t     mtime_wdata,
    output bus_pkg::data_t     mtimecmp
);

    bus_pkg::addr_t offset;
    logic           sel_cmp;
    logic           sel_time;
    logic           ready_q;
    bus_pkg::data_t rdata_q;
    bus_pkg::data_t rd_mux;

    assign offset   = clint_req.addr - bus_pkg::clint_base;
    assign sel_cmp  = (offset == bus_pkg::mtimecmp_offset);
    assign sel_time = (offset == bus_pkg::mtime_offset);

    // mtime lives in the timer, so its writes go out as a load pulse
    assign mtime_wr    = clint_valid & clint_req.write & sel_time;
    assign mtime_wdata = clint_req.wdata;

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            mtimecmp <= '1;
        end else if (clint_valid && clint_req.write && sel_cmp) begin
            mtimecmp <= clint_req.wdata;
        end
    end

    // unmapped offsets read as zero
    always_comb begin
        if (clint_req.write) begin
            rd_mux = '0;
        end else if (sel_cmp) begin
            rd_mux = mtimecmp;
        end else if (sel_time) begin
            rd_mux = mtime;
        end else begin
            rd_mux = '0;
        end
    end

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= clint_valid;
        end
    end

    always_ff @(posedge inst_selfdefine) begin
        if (clint_valid) begin
            rdata_q <= rd_mux;
        end
    end

    assign clint_rsp.ready = ready_q;
    assign clint_rsp.rdata = rdata_q;

    a_double_only: assert property (@(posedge inst_selfdefine) disable iff (reset)
        clint_valid |-> clint_req.size == bus_pkg::size_double);

endmodule

// File: source/bus_router.sv
`timescale 1ns/1ps

module bus_router (
    input  logic               inst_selfdefine,
    input  logic               reset,
    input  logic               bus_valid,
    input  bus_pkg::bus_req_t  bus_req,
    output bus_pkg::bus_rsp_t  bus_rsp,
    output logic               mem_valid,
    output bus_pkg::bus_req_t  mem_req,
    input  bus_pkg::bus_rsp_t  mem_rsp,
    output logic               clint_valid,
    output bus_pkg::bus_req_t  clint_req,
    input  bus_pkg::bus_rsp_t  clint_rsp
);

    logic hit_clint;
    logic pending_q;
    logic target_clint_q;
    logic rsp_ready;

    // CLINT region, everything else goes out to memory
    assign hit_clint = (bus_req.addr >= bus_pkg::clint_base) &&
                       (bus_req.addr < bus_pkg::clint_base + bus_pkg::clint_span);

    assign mem_valid   = bus_valid & ~hit_clint;
    assign clint_valid = bus_valid & hit_clint;

    // both targets see the request, only one gets the strobe
    assign mem_req   = bus_req;
    assign clint_req = bus_req;

    assign rsp_ready = target_clint_q ? clint_rsp.ready : mem_rsp.ready;

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            pending_q      <= 1'b0;
            target_clint_q <= 1'b0;
        end else if (bus_valid) begin
            pending_q      <= 1'b1;
            target_clint_q <= hit_clint;
        end else if (rsp_ready) begin
            pending_q      <= 1'b0;
        end
    end

    // steer the reply from whichever target took the access
    always_comb begin
        if (target_clint_q) begin
            bus_rsp = clint_rsp;
        end else begin
            bus_rsp = mem_rsp;
        end
    end

    a_mem_rsp_pending: assert property (@(posedge inst_selfdefine) disable iff (reset)
        mem_rsp.ready |-> pending_q && !target_clint_q);

    a_clint_rsp_pending: assert property (@(posedge inst_selfdefine) disable iff (reset)
        clint_rsp.ready |-> pending_q && target_clint_q);

endmodule

// File: source/access_align.sv
`timescale 1ns/1ps

module access_align (
    input  logic               inst_selfdefine,
    input  logic               reset,
    input  logic               acc_valid,
    input  lsu_pkg::acc_req_t  acc_req,
    output logic               acc_done,
    output bus_pkg::data_t     acc_rdata,
    output logic               bus_valid,
    output bus_pkg::bus_req_t  bus_req,
    input  bus_pkg::bus_rsp_t  bus_rsp
);

    logic             pending;
    lsu_pkg::ls_op_e  op_q;
    lsu_pkg::lane_t   lane_q;
    lsu_pkg::lane_t   req_lane;
    lsu_pkg::lane_t   align_mask;
    bus_pkg::data_t   store_raw;
    bus_pkg::data_t   lane_data;
    bus_pkg::data_t   load_data;
    logic             sign_ext;

    function automatic bus_pkg::bus_size_e op_size(lsu_pkg::ls_op_e op);
        case (op)
            lsu_pkg::op_lb, lsu_pkg::op_lbu, lsu_pkg::op_sb: return bus_pkg::size_byte;
            lsu_pkg::op_lh, lsu_pkg::op_lhu, lsu_pkg::op_sh: return bus_pkg::size_half;
            lsu_pkg::op_lw, lsu_pkg::op_lwu, lsu_pkg::op_sw: return bus_pkg::size_word;
            default: return bus_pkg::size_double;
        endcase
    endfunction

    function automatic logic op_write(lsu_pkg::ls_op_e op);
        return op inside {lsu_pkg::op_sb, lsu_pkg::op_sh, lsu_pkg::op_sw, lsu_pkg::op_sd};
    endfunction

    function automatic lsu_pkg::ext_e op_ext(lsu_pkg::ls_op_e op);
        if (op inside {lsu_pkg::op_lb, lsu_pkg::op_lh, lsu_pkg::op_lw}) begin
            return lsu_pkg::ext_sign;
        end
        return lsu_pkg::ext_zero;
    endfunction

    assign req_lane = acc_req.addr[2:0];

    // trim store data to its size, then move it into its lanes
    always_comb begin
        case (op_size(acc_req.op))
            bus_pkg::size_byte: begin
                store_raw  = {56'b0, acc_req.wdata[7:0]};
                align_mask = 3'b000;
            end
            bus_pkg::size_half: begin
                store_raw  = {48'b0, acc_req.wdata[15:0]};
                align_mask = 3'b001;
            end
            bus_pkg::size_word: begin
                store_raw  = {32'b0, acc_req.wdata[31:0]};
                align_mask = 3'b011;
            end
            default: begin
                store_raw  = acc_req.wdata;
                align_mask = 3'b111;
            end
        endcase
        bus_req.addr  = acc_req.addr;
        bus_req.size  = op_size(acc_req.op);
        bus_req.write = op_write(acc_req.op);
        bus_req.wdata = bus_req.write ? store_raw << {req_lane, 3'b000} : '0;
    end

    assign bus_valid = acc_valid;

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (acc_valid) begin
            pending <= 1'b1;
        end else if (bus_rsp.ready) begin
            pending <= 1'b0;
        end
    end

    // op and lane are needed again when the response comes back
    always_ff @(posedge inst_selfdefine) begin
        if (acc_valid) begin
            op_q   <= acc_req.op;
            lane_q <= req_lane;
        end
    end

    always_comb begin
        lane_data = bus_rsp.rdata >> {lane_q, 3'b000};
        sign_ext  = (op_ext(op_q) == lsu_pkg::ext_sign);
        case (op_size(op_q))
            bus_pkg::size_byte: load_data = {{56{sign_ext & lane_data[7]}}, lane_data[7:0]};
            bus_pkg::size_half: load_data = {{48{sign_ext & lane_data[15]}}, lane_data[15:0]};
            bus_pkg::size_word: load_data = {{32{sign_ext & lane_data[31]}}, lane_data[31:0]};
            default:            load_data = lane_data;
        endcase
    end

    assign acc_done  = bus_rsp.ready & pending;
    assign acc_rdata = op_write(op_q) ? '0 : load_data;

    a_natural_align: assert property (@(posedge inst_selfdefine) disable iff (reset)
        acc_valid |-> (req_lane & align_mask) == 3'b000);

    // requester must wait for acc_done
    a_one_outstanding: assert property (@(posedge inst_selfdefine) disable iff (reset)
        acc_valid |-> !pending);

endmodule

// File: source/lsu_top.sv
`timescale 1ns/1ps

module lsu_top (
    input  logic               inst_selfdefine,
    input  logic               reset,
    input  logic               acc_valid,
    input  lsu_pkg::acc_req_t  acc_req,
    output logic               acc_done,
    output bus_pkg::data_t     acc_rdata,
    output logic               mem_valid,
    output bus_pkg::bus_req_t  mem_req,
    input  bus_pkg::bus_rsp_t  mem_rsp,
    output logic               mtip
);

    logic               bus_valid;
    bus_pkg::bus_req_t  bus_req;
    bus_pkg::bus_rsp_t  bus_rsp;
    logic               clint_valid;
    bus_pkg::bus_req_t  clint_req;
    bus_pkg::bus_rsp_t  clint_rsp;
    logic               mtime_wr;
    bus_pkg::data_t     mtime_wdata;
    bus_pkg::data_t     mtimecmp;
    bus_pkg::data_t     mtime;

    access_align u_access_align (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .acc_valid       (acc_valid),
        .acc_req         (acc_req),
        .acc_done        (acc_done),
        .acc_rdata       (acc_rdata),
        .bus_valid       (bus_valid),
        .bus_req         (bus_req),
        .bus_rsp         (bus_rsp)
    );

    bus_router u_bus_router (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .bus_valid       (bus_valid),
        .bus_req         (bus_req),
        .bus_rsp         (bus_rsp),
        .mem_valid       (mem_valid),
        .mem_req         (mem_req),
        .mem_rsp         (mem_rsp),
        .clint_valid     (clint_valid),
        .clint_req       (clint_req),
        .clint_rsp       (clint_rsp)
    );

    clint_regs u_clint_regs (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .clint_valid     (clint_valid),
        .clint_req       (clint_req),
        .clint_rsp       (clint_rsp),
        .mtime           (mtime),
        .mtime_wr        (mtime_wr),
        .mtime_wdata     (mtime_wdata),
        .mtimecmp        (mtimecmp)
    );

    clint_timer u_clint_timer (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .mtime_wr        (mtime_wr),
        .mtime_wdata     (mtime_wdata),
        .mtimecmp        (mtimecmp),
        .mtime           (mtime),
        .mtip            (mtip)
    );

endmodule

// File: verif/ext_mem_model.sv
`timescale 1ns/1ps

module ext_mem_model (
    input  logic               inst_selfdefine,
    input  logic               reset,
    input  logic               mem_valid,
    input  bus_pkg::bus_req_t  mem_req,
    output bus_pkg::bus_rsp_t  mem_rsp
);

    localparam int depth = 512;

    bus_pkg::data_t mem [depth];
    bus_pkg::data_t wmask;
    bus_pkg::data_t rdata_q;
    logic [8:0]     idx;
    logic [8:0]     idx_q;
    logic           busy;
    logic           ready_q;
    int             wait_left;
    int             delay;
    int             i;

    assign idx = mem_req.addr[11:3];

    // every doubleword starts out distinct
    initial begin
        for (i = 0; i < depth; i++) begin
            mem[i] = {~32'(i), 32'(i) * 32'h9e37_79b9};
        end
    end

    always_comb begin
        case (mem_req.size)
            bus_pkg::size_byte: wmask = 64'h0000_0000_0000_00ff;
            bus_pkg::size_half: wmask = 64'h0000_0000_0000_ffff;
            bus_pkg::size_word: wmask = 64'h0000_0000_ffff_ffff;
            default:            wmask = '1;
        endcase
        wmask = wmask << {mem_req.addr[2:0], 3'b000};
    end

    always @(posedge inst_selfdefine) begin
        if (reset) begin
            busy    <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            ready_q <= 1'b0;
            if (mem_valid) begin
                idx_q <= idx;
                // ready comes 1 to 4 cycles later
                delay = int'($urandom % 4);
                if (delay == 0) begin
                    ready_q <= 1'b1;
                    rdata_q <= mem[idx];
                end else begin
                    busy      <= 1'b1;
                    wait_left <= delay - 1;
                end
                if (mem_req.write) begin
                    mem[idx] <= (mem[idx] & ~wmask) | (mem_req.wdata & wmask);
                end
            end else if (busy) begin
                if (wait_left == 0) begin
                    busy    <= 1'b0;
                    ready_q <= 1'b1;
                    rdata_q <= mem[idx_q];
                end else begin
                    wait_left <= wait_left - 1;
                end
            end
        end
    end

    assign mem_rsp.ready = ready_q;
    assign mem_rsp.rdata = rdata_q;

endmodule

// File: verif/tb_lsu_top.sv
`timescale 1ns/1ps

module tb_lsu_top;

    // about 80 accesses of up to 6 cycles each plus idle waits and a wide margin
    localparam int max_cycles = 2000;
    localparam bus_pkg::addr_t mem_base      = 64'h0000_0000_8000_0100;
    localparam bus_pkg::addr_t mtimecmp_addr = bus_pkg::clint_base + bus_pkg::mtimecmp_offset;
    localparam bus_pkg::addr_t mtime_addr    = bus_pkg::clint_base + bus_pkg::mtime_offset;

    logic               inst_selfdefine;
    logic               reset;
    logic               acc_valid;
    lsu_pkg::acc_req_t  acc_req;
    logic               acc_done;
    bus_pkg::data_t     acc_rdata;
    logic               mem_valid;
    bus_pkg::bus_req_t  mem_req;
    bus_pkg::bus_rsp_t  mem_rsp;
    logic               mtip;
    int                 cycle_count = 0;
    int                 error_count = 0;

    lsu_top UUT (.*);

    ext_mem_model u_ext_mem (.*);

    initial begin
        inst_selfdefine = 1'b0;
        forever #10 inst_selfdefine = ~inst_selfdefine;
    end

    task automatic stop_on_failure();
        error_count++;
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input bus_pkg::data_t expected,
                               input bus_pkg::data_t actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    always @(posedge inst_selfdefine) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout: the run did not finish within %0d clock cycles", max_cycles);
            stop_on_failure();
        end
    end

    function automatic int op_bytes(lsu_pkg::ls_op_e op);
        case (op)
            lsu_pkg::op_lb, lsu_pkg::op_lbu, lsu_pkg::op_sb: return 1;
            lsu_pkg::op_lh, lsu_pkg::op_lhu, lsu_pkg::op_sh: return 2;
            lsu_pkg::op_lw, lsu_pkg::op_lwu, lsu_pkg::op_sw: return 4;
            default: return 8;
        endcase
    endfunction

    function automatic bus_pkg::data_t lane_mask(lsu_pkg::ls_op_e op);
        if (op_bytes(op) == 8) begin
            return '1;
        end
        return (64'd1 << (op_bytes(op) * 8)) - 64'd1;
    endfunction

    // lane bytes with the top bit copied upward for signed loads
    function automatic bus_pkg::data_t expected_load(lsu_pkg::ls_op_e op,
                                                     bus_pkg::data_t dword, int lane);
        bus_pkg::data_t value;
        value = (dword >> (lane * 8)) & lane_mask(op);
        if (op inside {lsu_pkg::op_lb, lsu_pkg::op_lh, lsu_pkg::op_lw} &&
            value[op_bytes(op) * 8 - 1]) begin
            value = value | ~lane_mask(op);
        end
        return value;
    endfunction

    task automatic run_access(input string name, input lsu_pkg::ls_op_e op,
                              input bus_pkg::addr_t addr, input bus_pkg::data_t wdata,
                              output bus_pkg::data_t rdata, output int latency);
        logic is_clint;
        logic is_store;
        is_clint = (addr >= bus_pkg::clint_base) &&
                   (addr < bus_pkg::clint_base + bus_pkg::clint_span);
        is_store = op inside {lsu_pkg::op_sb, lsu_pkg::op_sh, lsu_pkg::op_sw, lsu_pkg::op_sd};
        @(negedge inst_selfdefine);
        acc_valid     = 1'b1;
        acc_req.op    = op;
        acc_req.addr  = addr;
        acc_req.wdata = wdata;
        #1;
        check_value($sformatf("%s acc_done with request", name), 64'd0, {63'd0, acc_done});
        check_value($sformatf("%s mem_valid", name), {63'd0, !is_clint}, {63'd0, mem_valid});
        if (!is_clint) begin
            check_value($sformatf("%s mem_req.addr", name), addr, mem_req.addr);
            check_value($sformatf("%s mem_req.size", name), 64'($clog2(op_bytes(op))),
                        {62'd0, mem_req.size});
            check_value($sformatf("%s mem_req.write", name), {63'd0, is_store},
                        {63'd0, mem_req.write});
            if (is_store) begin
                check_value($sformatf("%s mem_req.wdata", name),
                            (wdata & lane_mask(op)) << (int'(addr[2:0]) * 8), mem_req.wdata);
            end
        end
        @(negedge inst_selfdefine);
        acc_valid = 1'b0;
        acc_req   = '0;
        latency   = 1;
        #1;
        while (!acc_done) begin
            check_value($sformatf("%s mem_valid while pending", name), 64'd0,
                        {63'd0, mem_valid});
            @(negedge inst_selfdefine);
            #1;
            latency++;
        end
        rdata = acc_rdata;
        if (is_store) begin
            check_value($sformatf("%s store result", name), 64'd0, rdata);
        end
        if (is_clint) begin
            check_value($sformatf("%s clint latency", name), 64'd1, 64'(latency));
        end else if (latency > 4) begin
            $display("%s: acc_done came %0d cycles after mem_valid", name, latency);
            stop_on_failure();
        end
        @(negedge inst_selfdefine);
        #1;
        check_value($sformatf("%s single acc_done", name), 64'd0, {63'd0, acc_done});
    endtask

    task automatic store_value(input string name, input lsu_pkg::ls_op_e op,
                               input bus_pkg::addr_t addr, input bus_pkg::data_t wdata);
        bus_pkg::data_t rdata;
        int latency;
        run_access(name, op, addr, wdata, rdata, latency);
    endtask

    task automatic load_and_check(input string name, input lsu_pkg::ls_op_e op,
                                  input bus_pkg::addr_t addr, input bus_pkg::data_t expected);
        bus_pkg::data_t rdata;
        int latency;
        run_access(name, op, addr, 64'd0, rdata, latency);
        check_value(name, expected, rdata);
    endtask

    task automatic wait_for_mtip(input logic level, input int limit, input string name);
        int waited;
        waited = 0;
        while (mtip !== level) begin
            if (waited == limit) begin
                $display("%s: mtip did not reach %b within %0d cycles", name, level, limit);
                stop_on_failure();
            end
            @(negedge inst_selfdefine);
            #1;
            waited++;
        end
    endtask

    task automatic test_width_extension();
        lsu_pkg::ls_op_e loads [7];
        bus_pkg::data_t  dword;
        int              lane;
        int              k;
        loads = '{lsu_pkg::op_lb, lsu_pkg::op_lbu, lsu_pkg::op_lh, lsu_pkg::op_lhu,
                  lsu_pkg::op_lw, lsu_pkg::op_lwu, lsu_pkg::op_ld};
        dword = 64'hf1e2_83a4_7586_97c8;
        store_value("width_extension sd", lsu_pkg::op_sd, mem_base, dword);
        for (lane = 0; lane < 8; lane++) begin
            for (k = 0; k < 7; k++) begin
                if (lane % op_bytes(loads[k]) == 0) begin
                    load_and_check($sformatf("width_extension %s @%0d", loads[k].name(), lane),
                                   loads[k], mem_base + 64'(lane),
                                   expected_load(loads[k], dword, lane));
                end
            end
        end
    endtask

    // narrow stores fill a doubleword piece by piece from the lowest offset
    task automatic compose_and_check(input lsu_pkg::ls_op_e op, input bus_pkg::addr_t base);
        bus_pkg::data_t expected;
        bus_pkg::data_t piece;
        int             nbytes;
        int             i;
        nbytes   = op_bytes(op);
        expected = '0;
        for (i = 0; i < 8 / nbytes; i++) begin
            piece    = {$urandom, $urandom};
            expected = expected | ((piece & lane_mask(op)) << (i * nbytes * 8));
            store_value($sformatf("lane_composition %s", op.name()), op,
                        base + 64'(i * nbytes), piece);
        end
        load_and_check($sformatf("lane_composition %s", op.name()), lsu_pkg::op_ld, base,
                       expected);
    endtask

    task automatic test_random_latency();
        bus_pkg::addr_t addr;
        bus_pkg::data_t value;
        int             i;
        for (i = 0; i < 12; i++) begin
            addr  = mem_base + 64'h40 + 64'(($urandom % 16) * 8);
            value = {$urandom, $urandom};
            store_value("random_latency sd", lsu_pkg::op_sd, addr, value);
            load_and_check("random_latency ld", lsu_pkg::op_ld, addr, value);
        end
    endtask

    task automatic test_clint_access();
        store_value("clint_access sd", lsu_pkg::op_sd, mtimecmp_addr, 64'h0123_4567_89ab_cdef);
        load_and_check("clint_access ld", lsu_pkg::op_ld, mtimecmp_addr,
                       64'h0123_4567_89ab_cdef);
    endtask

    task automatic test_timer_interrupt();
        bus_pkg::data_t start;
        bus_pkg::data_t now;
        int             latency;
        start = 64'h0000_0000_0000_1000;
        store_value("timer mtime write", lsu_pkg::op_sd, mtime_addr, start);
        repeat (10) @(negedge inst_selfdefine);
        run_access("timer mtime read", lsu_pkg::op_ld, mtime_addr, 64'd0, now, latency);
        if (now < start + 64'd10 || now > start + 64'd14) begin
            $display("timer: mtime read back as %h, outside %h to %h", now,
                     start + 64'd10, start + 64'd14);
            stop_on_failure();
        end
        check_value("timer mtip before compare", 64'd0, {63'd0, mtip});
        store_value("timer mtimecmp ahead", lsu_pkg::op_sd, mtimecmp_addr, now + 64'd6);
        wait_for_mtip(1'b1, 8, "timer mtip rise");
        store_value("timer mtimecmp max", lsu_pkg::op_sd, mtimecmp_addr, '1);
        wait_for_mtip(1'b0, 2, "timer mtip drop");
    endtask

    initial begin
        void'($urandom(32'h5295a470));
        reset     = 1'b1;
        acc_valid = 1'b0;
        acc_req   = '0;
        repeat (2) @(posedge inst_selfdefine);
        @(negedge inst_selfdefine);
        reset = 1'b0;
        test_width_extension();
        compose_and_check(lsu_pkg::op_sb, mem_base + 64'h08);
        compose_and_check(lsu_pkg::op_sh, mem_base + 64'h10);
        compose_and_check(lsu_pkg::op_sw, mem_base + 64'h18);
        test_random_latency();
        test_clint_access();
        test_timer_interrupt();
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            stop_on_failure();
        end
    end

endmodule

// File: files.f
source/bus_pkg.sv
source/lsu_pkg.sv
source/clint_timer.sv
source/clint_regs.sv
source/bus_router.sv
source/access_align.sv
source/lsu_top.sv
verif/ext_mem_model.sv
verif/tb_lsu_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_lsu_top
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
